// ==== design/mexq_cfg.svh ====
`ifndef MEXQ_CFG_SVH
`define MEXQ_CFG_SVH

// Number of memory-stage wait queue slots
`define MEXQ_SLOTS 8

// Source operands carried by each memory instruction
`define MEXQ_OPS 4

`define MEXQ_DATA_W 64

// Producer tag width that the instruction tag shares
`define MEXQ_TAG_W 7

`define MEXQ_WB_PORTS 4

// Wake bits in order read-even, swizzle-even, read-odd, swizzle-odd
`define MEXQ_WAKE_W 4

`endif

// ==== design/mexq_types_pkg.sv ====
`include "mexq_cfg.svh"

package mexq_types_pkg;

    // One source operand as held in a slot
    typedef struct packed {
        logic                    present;
        logic [`MEXQ_TAG_W-1:0]  tag;
        logic [`MEXQ_DATA_W-1:0] data;
    } operand_t;

    typedef struct packed {
        logic [`MEXQ_TAG_W-1:0]            itag;
        operand_t [`MEXQ_OPS-1:0]          ops;
        logic [`MEXQ_WAKE_W-1:0]           wake_need;
    } dispatch_t;

    typedef struct packed {
        logic                    valid;
        logic [`MEXQ_WAKE_W-1:0] wake_got;
        dispatch_t               entry;
    } slot_t;

    // A writeback port or the aligned cache return
    typedef struct packed {
        logic                    valid;
        logic [`MEXQ_TAG_W-1:0]  tag;
        logic [`MEXQ_DATA_W-1:0] data;
    } result_bus_t;

    typedef struct packed {
        logic [`MEXQ_SLOTS-1:0]  cache_qslot;
        logic [`MEXQ_WAKE_W-1:0] cache_wake;
        logic [`MEXQ_SLOTS-1:0]  rd_e;
        logic [`MEXQ_SLOTS-1:0]  sw_e;
        logic [`MEXQ_SLOTS-1:0]  rd_o;
        logic [`MEXQ_SLOTS-1:0]  sw_o;
    } wake_in_t;

endpackage

// ==== design/mexq_apb_pkg.sv ====
package mexq_apb_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    localparam logic [7:0] REG_CTRL    = 8'h00;
    localparam logic [7:0] REG_STATUS  = 8'h04;
    localparam logic [7:0] REG_TIMEOUT = 8'h08;
    localparam logic [7:0] REG_CLEAR   = 8'h0C;

    // Queue controller states as reported in STATUS bits 1:0
    typedef enum logic [1:0] {IDLE = 2'd0, RUN = 2'd1, DRAIN = 2'd2, HUNG = 2'd3} ctrl_state_e;

endpackage

// ==== design/operand_bypass.sv ====
`timescale 1ns/1ns
`include "mexq_cfg.svh"

module operand_bypass (
    input  mexq_types_pkg::operand_t    [`MEXQ_OPS-1:0]      ops,
    input  mexq_types_pkg::result_bus_t [`MEXQ_WB_PORTS-1:0] wb,
    input  mexq_types_pkg::result_bus_t                      cache_ret,
    output mexq_types_pkg::operand_t    [`MEXQ_OPS-1:0]      ops_new,
    output logic                        [`MEXQ_OPS-1:0]      modified
);

    // Lower writeback ports override the cache return, and wb0 has the last word
    // A writeback carrying the cache return's tag also matches the operand and wins
    always_comb begin
        ops_new  = ops;
        modified = '0;
        for (int o = 0; o < `MEXQ_OPS; o++) begin
            if (!ops[o].present) begin
                if (cache_ret.valid && cache_ret.tag == ops[o].tag) begin
                    ops_new[o].present = 1'b1;
                    ops_new[o].data    = cache_ret.data;
                    modified[o]        = 1'b1;
                end
                for (int p = `MEXQ_WB_PORTS - 1; p >= 0; p--) begin
                    if (wb[p].valid && wb[p].tag == ops[o].tag) begin
                        ops_new[o].present = 1'b1;
                        ops_new[o].data    = wb[p].data;
                        modified[o]        = 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== design/mexq_slot_array.sv ====
`timescale 1ns/1ns
`include "mexq_cfg.svh"

module mexq_slot_array (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             alloc_en,
    input  logic                                             disp_valid,
    output logic                                             disp_ready,
    input  mexq_types_pkg::dispatch_t                        disp_entry,
    output logic                                             iss_valid,
    input  logic                                             iss_ready,
    output mexq_types_pkg::dispatch_t                        iss_entry,
    input  mexq_types_pkg::result_bus_t [`MEXQ_WB_PORTS-1:0] wb,
    input  mexq_types_pkg::result_bus_t                      cache_ret,
    input  mexq_types_pkg::wake_in_t                         wake,
    output logic [3:0]                                       occupancy,
    output logic                                             issued
);
    import mexq_types_pkg::*;

    localparam int IDX_W = $clog2(`MEXQ_SLOTS);

    slot_t                    slot_q   [`MEXQ_SLOTS];
    operand_t [`MEXQ_OPS-1:0] ops_new  [`MEXQ_SLOTS];
    logic [`MEXQ_OPS-1:0]     ops_mod  [`MEXQ_SLOTS];
    logic [`MEXQ_WAKE_W-1:0]  wake_hit [`MEXQ_SLOTS];
    operand_t [`MEXQ_OPS-1:0] disp_ops;
    dispatch_t                disp_cap;
    logic [`MEXQ_SLOTS-1:0]   free;
    logic [`MEXQ_SLOTS-1:0]   eligible;
    logic [IDX_W-1:0]         alloc_idx;
    logic [IDX_W-1:0]         iss_idx;
    logic                     disp_fire;

    function automatic logic ops_ready(input operand_t [`MEXQ_OPS-1:0] ops);
        logic ready;
        ready = 1'b1;
        for (int o = 0; o < `MEXQ_OPS; o++) begin
            ready = ready & ops[o].present;
        end
        return ready;
    endfunction

    for (genvar i = 0; i < `MEXQ_SLOTS; i++) begin : g_slot
        operand_bypass u_bypass (
            .ops       (slot_q[i].entry.ops),
            .wb        (wb),
            .cache_ret (cache_ret),
            .ops_new   (ops_new[i]),
            .modified  (ops_mod[i])
        );

        // Wake bits follow the MSHR mask order rd_e, sw_e, rd_o, sw_o
        assign wake_hit[i] = ({`MEXQ_WAKE_W{wake.cache_qslot[i]}} & wake.cache_wake)
                           | {wake.sw_o[i], wake.rd_o[i], wake.sw_e[i], wake.rd_e[i]};
    end

    // The entry being dispatched also sees this cycle's broadcasts
    operand_bypass u_disp_bypass (
        .ops       (disp_entry.ops),
        .wb        (wb),
        .cache_ret (cache_ret),
        .ops_new   (disp_ops),
        .modified  ()
    );

    always_comb begin
        disp_cap     = disp_entry;
        disp_cap.ops = disp_ops;
    end

    always_comb begin
        for (int i = 0; i < `MEXQ_SLOTS; i++) begin
            free[i]     = !slot_q[i].valid;
            eligible[i] = slot_q[i].valid && ops_ready(slot_q[i].entry.ops)
                       && ((slot_q[i].wake_got & slot_q[i].entry.wake_need)
                           == slot_q[i].entry.wake_need);
        end
    end

    // The lowest index wins the pick for both allocation and issue
    always_comb begin
        alloc_idx = '0;
        iss_idx   = '0;
        for (int i = `MEXQ_SLOTS - 1; i >= 0; i--) begin
            if (free[i]) begin
                alloc_idx = IDX_W'(i);
            end
            if (eligible[i]) begin
                iss_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        occupancy = '0;
        for (int i = 0; i < `MEXQ_SLOTS; i++) begin
            occupancy = occupancy + 4'(slot_q[i].valid);
        end
    end

    assign disp_ready = alloc_en && |free;
    assign disp_fire  = disp_valid && disp_ready;
    assign iss_valid  = |eligible;
    assign iss_entry  = slot_q[iss_idx].entry;
    assign issued     = iss_valid && iss_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MEXQ_SLOTS; i++) begin
                slot_q[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `MEXQ_SLOTS; i++) begin
                if (issued && iss_idx == IDX_W'(i)) begin
                    slot_q[i].valid <= 1'b0;
                end else if (disp_fire && alloc_idx == IDX_W'(i)) begin
                    slot_q[i].valid    <= 1'b1;
                    slot_q[i].wake_got <= wake_hit[i];
                    slot_q[i].entry    <= disp_cap;
                end else if (slot_q[i].valid) begin
                    slot_q[i].wake_got <= slot_q[i].wake_got | wake_hit[i];
                    if (|ops_mod[i]) begin
                        slot_q[i].entry.ops <= ops_new[i];
                    end
                end
            end
        end
    end

endmodule

// ==== design/age_timer.sv ====
`timescale 1ns/1ns

module age_timer (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        busy,
    input  logic        issued,
    input  logic [15:0] limit,
    output logic        expired
);

    logic [15:0] count;

    // Age of the oldest stretch without forward progress
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (issued || !busy) begin
            count <= '0;
        end else if (count != '1) begin
            count <= count + 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            expired <= 1'b0;
        end else begin
            expired <= busy && !issued && (count == limit);
        end
    end

endmodule

// ==== design/mexq_ctrl_fsm.sv ====
`timescale 1ns/1ns

module mexq_ctrl_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      enable,
    input  logic                      drain,
    input  logic                      clear,
    input  logic                      expired,
    input  logic [3:0]                occupancy,
    output mexq_apb_pkg::ctrl_state_e state,
    output logic                      alloc_en,
    output logic                      ctrl_done
);
    import mexq_apb_pkg::*;

    ctrl_state_e state_next;

    always_comb begin
        state_next = state;
        ctrl_done  = 1'b0;
        case (state)
            IDLE: begin
                if (enable) begin
                    state_next = RUN;
                end
            end
            RUN: begin
                if (expired) begin
                    state_next = HUNG;
                end else if (drain) begin
                    state_next = DRAIN;
                end
            end
            DRAIN: begin
                if (expired) begin
                    state_next = HUNG;
                end else if (occupancy == 4'd0) begin
                    state_next = IDLE;
                    ctrl_done  = 1'b1;
                end
            end
            HUNG: begin
                // Software must re-enable after recovering a stuck queue
                if (clear) begin
                    state_next = IDLE;
                    ctrl_done  = 1'b1;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign alloc_en = (state == RUN);

endmodule

// ==== design/mexq_apb_regs.sv ====
`timescale 1ns/1ns

module mexq_apb_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mexq_apb_pkg::apb_req_t    apb_req,
    output mexq_apb_pkg::apb_rsp_t    apb_rsp,
    input  mexq_apb_pkg::ctrl_state_e state,
    input  logic [3:0]                occupancy,
    input  logic                      ctrl_done,
    output logic                      enable,
    output logic                      drain,
    output logic                      clear,
    output logic [15:0]               limit
);
    import mexq_apb_pkg::*;

    logic access;
    logic wr;
    logic mapped;

    assign access = apb_req.psel && apb_req.penable;
    assign wr     = access && apb_req.pwrite;
    assign mapped = apb_req.paddr inside {REG_CTRL, REG_STATUS, REG_TIMEOUT, REG_CLEAR};
    assign clear  = wr && apb_req.paddr == REG_CLEAR && apb_req.pwdata[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable <= 1'b0;
            drain  <= 1'b0;
            limit  <= 16'd255;
        end else begin
            // Leaving DRAIN or HUNG wins over a CTRL write in the same cycle
            if (ctrl_done) begin
                enable <= 1'b0;
                drain  <= 1'b0;
            end else if (wr && apb_req.paddr == REG_CTRL) begin
                enable <= apb_req.pwdata[0];
                drain  <= apb_req.pwdata[1];
            end
            if (wr && apb_req.paddr == REG_TIMEOUT) begin
                limit <= apb_req.pwdata[15:0];
            end
        end
    end

    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && apb_req.paddr == REG_STATUS));
        case (apb_req.paddr)
            REG_CTRL:    apb_rsp.prdata = {30'd0, drain, enable};
            REG_STATUS:  apb_rsp.prdata = {23'd0, state == HUNG, occupancy, 2'd0, state};
            REG_TIMEOUT: apb_rsp.prdata = {16'd0, limit};
            default:     apb_rsp.prdata = '0;
        endcase
    end

endmodule

// ==== design/mexq_top.sv ====
`timescale 1ns/1ns
`include "mexq_cfg.svh"

module mexq_top (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  mexq_apb_pkg::apb_req_t                           apb_req,
    output mexq_apb_pkg::apb_rsp_t                           apb_rsp,
    input  logic                                             disp_valid,
    output logic                                             disp_ready,
    input  mexq_types_pkg::dispatch_t                        disp_entry,
    output logic                                             iss_valid,
    input  logic                                             iss_ready,
    output mexq_types_pkg::dispatch_t                        iss_entry,
    input  mexq_types_pkg::result_bus_t [`MEXQ_WB_PORTS-1:0] wb,
    input  mexq_types_pkg::result_bus_t                      cache_ret,
    input  mexq_types_pkg::wake_in_t                         wake
);
    import mexq_apb_pkg::*;

    ctrl_state_e state;
    logic        alloc_en;
    logic        ctrl_done;
    logic        enable;
    logic        drain;
    logic        clear;
    logic        expired;
    logic        issued;
    logic [3:0]  occupancy;
    logic [15:0] limit;

    mexq_slot_array u_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc_en   (alloc_en),
        .disp_valid (disp_valid),
        .disp_ready (disp_ready),
        .disp_entry (disp_entry),
        .iss_valid  (iss_valid),
        .iss_ready  (iss_ready),
        .iss_entry  (iss_entry),
        .wb         (wb),
        .cache_ret  (cache_ret),
        .wake       (wake),
        .occupancy  (occupancy),
        .issued     (issued)
    );

    // Only a non-empty queue can be stuck
    age_timer u_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .busy    (occupancy != 4'd0),
        .issued  (issued),
        .limit   (limit),
        .expired (expired)
    );

    mexq_ctrl_fsm u_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .drain     (drain),
        .clear     (clear),
        .expired   (expired),
        .occupancy (occupancy),
        .state     (state),
        .alloc_en  (alloc_en),
        .ctrl_done (ctrl_done)
    );

    mexq_apb_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .state     (state),
        .occupancy (occupancy),
        .ctrl_done (ctrl_done),
        .enable    (enable),
        .drain     (drain),
        .clear     (clear),
        .limit     (limit)
    );

endmodule

// ==== dv/mexq_tests.svh ====
task automatic reg_access_reset();
    logic [31:0] rd;
    logic        err;
    apb_read(REG_STATUS, rd);
    check("reset_status", 320'(status_val(IDLE, 4'd0, 1'b0)), 320'(rd));
    apb_read(REG_TIMEOUT, rd);
    check("reset_timeout", 320'(32'd255), 320'(rd));
    check("reset_disp_ready", 320'(1'b0), 320'(disp_ready));
    check("reset_iss_valid", 320'(1'b0), 320'(iss_valid));
    apb_write(REG_STATUS, 32'h1, err);
    check("status_write_err", 320'(1'b1), 320'(err));
    apb_write(8'h20, 32'h1, err);
    check("unmapped_write_err", 320'(1'b1), 320'(err));
    apb_write(REG_CTRL, 32'h1, err);
    check("ctrl_write_err", 320'(1'b0), 320'(err));
    // RUN begins on the edge after the write
    check("enable_pending", 320'(1'b0), 320'(disp_ready));
    next_cycle();
    check("enable_ready", 320'(1'b1), 320'(disp_ready));
endtask

task automatic slot_order_issue();
    dispatch_t   e [8];
    logic [31:0] rd;
    for (int i = 0; i < 3; i++) begin
        e[i] = ready_entry(7'(i));
        dispatch(e[i]);
    end
    apb_read(REG_STATUS, rd);
    check("order_occupancy", 320'(status_val(RUN, 4'd3, 1'b0)), 320'(rd));
    for (int i = 0; i < 3; i++) begin
        expect_issue("order_issue", e[i]);
    end
    for (int i = 0; i < 8; i++) begin
        e[i] = ready_entry(7'(16 + i));
        dispatch(e[i]);
    end
    check("order_full", 320'(1'b0), 320'(disp_ready));
    for (int i = 0; i < 8; i++) begin
        expect_issue("order_full_issue", e[i]);
    end
endtask

task automatic operand_capture();
    dispatch_t                e;
    dispatch_t                exp;
    logic [`MEXQ_DATA_W-1:0]  d [6];
    for (int i = 0; i < 6; i++) begin
        d[i] = rand_data();
    end
    e = ready_entry(7'h30);
    for (int o = 0; o < `MEXQ_OPS; o++) begin
        e.ops[o].present = 1'b0;
        e.ops[o].tag     = 7'h10 + 7'(o);
    end
    exp = e;
    for (int o = 0; o < `MEXQ_OPS; o++) begin
        exp.ops[o].present = 1'b1;
    end
    exp.ops[0].data = d[0];
    exp.ops[1].data = d[1];
    exp.ops[2].data = d[3];
    exp.ops[3].data = d[5];
    // Broadcast in the transfer cycle
    wb[2] = {1'b1, 7'h10, d[0]};
    dispatch(e);
    wb    = '0;
    wb[1] = {1'b1, 7'h11, d[1]};
    wb[3] = {1'b1, 7'h11, d[2]};
    next_cycle();
    wb        = '0;
    wb[3]     = {1'b1, 7'h12, d[3]};
    cache_ret = {1'b1, 7'h12, d[4]};
    next_cycle();
    wb        = '0;
    cache_ret = {1'b1, 7'h13, d[5]};
    next_cycle();
    cache_ret = '0;
    expect_issue("capture_entry", exp);
endtask

task automatic wake_gating();
    dispatch_t e;
    e           = ready_entry(7'h40);
    e.wake_need = 4'b0110;
    dispatch(e);
    // Slot 0 gets read-even only, which it does not need
    wake.cache_qslot = 8'h20;
    wake.cache_wake  = 4'hf;
    wake.rd_e        = 8'hff;
    wake.sw_o        = 8'hfe;
    next_cycle();
    wake = '0;
    #3;
    check("wake_unrelated", 320'(1'b0), 320'(iss_valid));
    next_cycle();
    wake.cache_qslot = 8'h01;
    wake.cache_wake  = 4'b0010;
    next_cycle();
    wake = '0;
    #3;
    check("wake_partial", 320'(1'b0), 320'(iss_valid));
    next_cycle();
    wake.rd_o = 8'h01;
    next_cycle();
    wake = '0;
    expect_issue("wake_issue", e);
endtask

task automatic drain_and_hang();
    dispatch_t   e [2];
    dispatch_t   stuck;
    logic [31:0] rd;
    logic        err;
    int          start;
    for (int i = 0; i < 2; i++) begin
        e[i] = ready_entry(7'(80 + i));
        dispatch(e[i]);
    end
    apb_write(REG_CTRL, 32'h3, err);
    next_cycle();
    check("drain_disp_ready", 320'(1'b0), 320'(disp_ready));
    expect_issue("drain_issue0", e[0]);
    expect_issue("drain_issue1", e[1]);
    next_cycle();
    apb_read(REG_STATUS, rd);
    check("drain_idle", 320'(status_val(IDLE, 4'd0, 1'b0)), 320'(rd));
    apb_read(REG_CTRL, rd);
    check("drain_ctrl_clear", 320'(32'd0), 320'(rd));
    apb_write(REG_TIMEOUT, 32'd20, err);
    apb_write(REG_CTRL, 32'h1, err);
    // Tag 7f never appears on any result bus
    stuck                = ready_entry(7'h60);
    stuck.ops[2].present = 1'b0;
    stuck.ops[2].tag     = 7'h7f;
    dispatch(stuck);
    start = cycles;
    apb_read(REG_STATUS, rd);
    while (rd[1:0] != HUNG) begin
        apb_read(REG_STATUS, rd);
    end
    check("hang_status", 320'(status_val(HUNG, 4'd1, 1'b1)), 320'(rd));
    check("hang_delay", 320'(1'b1), 320'(cycles - start > 20));
    apb_write(REG_CLEAR, 32'h1, err);
    apb_read(REG_STATUS, rd);
    check("clear_idle", 320'(status_val(IDLE, 4'd1, 1'b0)), 320'(rd));
endtask

// ==== dv/mexq_tb.sv ====
`timescale 1ns/1ns
`include "mexq_cfg.svh"

module mexq_tb;
    import mexq_types_pkg::*;
    import mexq_apb_pkg::*;

    // Twice the summed cycle budgets of the directed tests
    localparam int CYCLE_LIMIT = 4000;

    logic                             clk;
    logic                             rst_n;
    apb_req_t                         apb_req;
    apb_rsp_t                         apb_rsp;
    logic                             disp_valid;
    logic                             disp_ready;
    dispatch_t                        disp_entry;
    logic                             iss_valid;
    logic                             iss_ready;
    dispatch_t                        iss_entry;
    result_bus_t [`MEXQ_WB_PORTS-1:0] wb;
    result_bus_t                      cache_ret;
    wake_in_t                         wake;
    int                               cycles;
    integer                           seed;

    mexq_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .disp_valid (disp_valid),
        .disp_ready (disp_ready),
        .disp_entry (disp_entry),
        .iss_valid  (iss_valid),
        .iss_ready  (iss_ready),
        .iss_entry  (iss_entry),
        .wb         (wb),
        .cache_ret  (cache_ret),
        .wake       (wake)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("tests failed");
            $fatal(1, "simulation did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input logic [319:0] expected,
                         input logic [319:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        next_cycle();
        apb_req.penable = 1'b1;
        #3;
        err = apb_rsp.pslverr;
        check("apb_write_pready", 320'(1'b1), 320'(apb_rsp.pready));
        next_cycle();
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwdata  = '0;
        next_cycle();
        apb_req.penable = 1'b1;
        #3;
        data = apb_rsp.prdata;
        check("apb_read_pready", 320'(1'b1), 320'(apb_rsp.pready));
        next_cycle();
        apb_req = '0;
    endtask

    task automatic dispatch(input dispatch_t entry);
        disp_entry = entry;
        disp_valid = 1'b1;
        #3;
        while (!disp_ready) begin
            next_cycle();
            #3;
        end
        next_cycle();
        disp_valid = 1'b0;
    endtask

    task automatic expect_issue(input string name, input dispatch_t expected);
        iss_ready = 1'b1;
        #3;
        while (!iss_valid) begin
            next_cycle();
            #3;
        end
        check(name, 320'(expected), 320'(iss_entry));
        next_cycle();
        iss_ready = 1'b0;
    endtask

    function automatic logic [`MEXQ_DATA_W-1:0] rand_data();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic dispatch_t ready_entry(input logic [`MEXQ_TAG_W-1:0] itag);
        dispatch_t   e;
        logic [31:0] r;
        e.itag      = itag;
        e.wake_need = '0;
        for (int o = 0; o < `MEXQ_OPS; o++) begin
            r                = $random(seed);
            e.ops[o].present = 1'b1;
            e.ops[o].tag     = r[`MEXQ_TAG_W-1:0];
            e.ops[o].data    = rand_data();
        end
        return e;
    endfunction

    // STATUS holds the state in 1:0, occupancy in 7:4 and hung in 8
    function automatic logic [31:0] status_val(input logic [1:0] st, input logic [3:0] occ,
                                               input logic hung);
        return {23'd0, hung, occ, 2'd0, st};
    endfunction

    `include "mexq_tests.svh"

    initial begin
        seed       = 32'h4e35;
        cycles     = 0;
        rst_n      = 1'b0;
        apb_req    = '0;
        disp_valid = 1'b0;
        disp_entry = '0;
        iss_ready  = 1'b0;
        wb         = '0;
        cache_ret  = '0;
        wake       = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reg_access_reset();
        slot_order_issue();
        operand_capture();
        wake_gating();
        drain_and_hang();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+design
+incdir+dv
design/mexq_types_pkg.sv
design/mexq_apb_pkg.sv
design/operand_bypass.sv
design/mexq_slot_array.sv
design/age_timer.sv
design/mexq_ctrl_fsm.sv
design/mexq_apb_regs.sv
design/mexq_top.sv
dv/mexq_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ns --top-module mexq_tb -f sources.f -o mexq_sim &&
./obj_dir/mexq_sim ||
{ echo "simulation returned a failing status"; exit 1; }
